// File: filelist.f
src/tetris_score_pkg.sv
src/clear_event_if.sv
src/line_clear_tracker.sv
src/clear_points_calc.sv
src/bcd_score_accum.sv
src/tetris_scoring_top.sv
tb/tb_tetris_scoring.sv

// File: Makefile
# Verilator build and run for the scoring unit testbench

VERILATOR ?= verilator
TOP       ?= tb_tetris_scoring
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status follows the search for the pass line in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_tetris_scoring.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tetris_scoring
  import tetris_score_pkg::*;
;

  localparam int SCORE_DIGITS = 8;
  localparam int STEP_LIMIT   = 40;

  typedef bcd_digit_t [SCORE_DIGITS-1:0] score_t;

  // Reference tables, base points and gravity frames per level
  localparam int BASE_REF [5] = '{0, 40, 100, 300, 1200};
  localparam gravity_t GRAVITY_REF [16] = '{
    6'd40, 6'd37, 6'd34, 6'd30, 6'd26, 6'd21, 6'd15, 6'd12,
    6'd8,  6'd6,  6'd5,  6'd5,  6'd5,  6'd4,  6'd3,  6'd2
  };

  logic         clk;
  logic         rst;
  logic         new_game;
  logic         clear_valid;
  lines_t       clear_lines;
  score_t       score;
  total_lines_t total_lines;
  level_t       level;
  gravity_t     gravity_frames;

  int errors   = 0;
  int timeouts = 0;
  int seed     = 32'h3689;
  // Reference model state
  int m_total  = 0;
  int m_streak = 0;
  int m_level  = 0;
  int m_score  = 0;

  tetris_scoring_top #(
    .SCORE_DIGITS (SCORE_DIGITS)
  ) dut (
    .clk            (clk),
    .rst            (rst),
    .new_game       (new_game),
    .clear_valid    (clear_valid),
    .clear_lines    (clear_lines),
    .score          (score),
    .total_lines    (total_lines),
    .level          (level),
    .gravity_frames (gravity_frames)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // Reference model
  // ==============================
  function automatic score_t to_bcd(input int value);
    score_t digits;
    int     rest;
    rest = value;
    for (int i = 0; i < SCORE_DIGITS; i++) begin
      digits[i] = bcd_digit_t'(rest % 10);
      rest      = rest / 10;
    end
    return digits;
  endfunction

  task automatic model_clear(input int lines);
    int pts;
    int steps;
    steps = (m_streak > 5) ? 5 : m_streak;
    pts   = BASE_REF[lines] * (m_level + 1);
    if (lines != 0 && m_streak > 0) begin
      pts = pts + 100 * steps;
    end
    m_score  = (m_score + pts) % 100000000;
    m_total  = (m_total + lines > 255) ? 255 : m_total + lines;
    m_level  = (m_total / 10 > 15) ? 15 : m_total / 10;
    m_streak = (lines == 0) ? 0 : ((m_streak >= 15) ? 15 : m_streak + 1);
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_score(input score_t got, input score_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: score = %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_level(input level_t got, input level_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: level = %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_total(input total_lines_t got, input total_lines_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: total_lines = %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_gravity(input gravity_t got, input gravity_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: gravity_frames = %0d, expected %0d", $time, got, exp);
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  // Returns right after the edge that samples the event
  task automatic send_clear(input int lines);
    @(posedge clk);
    clear_valid <= 1'b1;
    clear_lines <= lines_t'(lines);
    model_clear(lines);
    @(posedge clk);
    clear_valid <= 1'b0;
  endtask

  task automatic start_game();
    @(posedge clk);
    new_game <= 1'b1;
    @(posedge clk);
    new_game <= 1'b0;
    m_total  = 0;
    m_streak = 0;
    m_level  = 0;
    m_score  = 0;
  endtask

  task automatic check_tracker();
    @(negedge clk);
    check_total(total_lines, total_lines_t'(m_total));
    check_level(level, level_t'(m_level));
    check_gravity(gravity_frames, GRAVITY_REF[m_level]);
  endtask

  // Score shows the event from the third edge after sampling
  task automatic check_points();
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_score(score, to_bcd(m_score));
  endtask

  task automatic clear_and_check(input int lines);
    send_clear(lines);
    check_tracker();
    check_points();
  endtask

  task automatic random_burst(input int count);
    int r;
    for (int n = 0; n < count; n++) begin
      @(posedge clk);
      r = $random(seed);
      clear_valid <= 1'b1;
      clear_lines <= lines_t'((r & 32'h7fffffff) % 5);
      model_clear((r & 32'h7fffffff) % 5);
    end
    // Edge that samples the last event
    @(posedge clk);
    clear_valid <= 1'b0;
    check_tracker();
    check_points();
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int tries;
    rst         = 1'b1;
    new_game    = 1'b0;
    clear_valid = 1'b0;
    clear_lines = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    check_tracker();
    check_score(score, to_bcd(0));

    // Base table, streak broken before each
    for (int l = 1; l <= 4; l++) begin
      clear_and_check(0);
      clear_and_check(l);
    end

    // Streak bonus caps at five steps
    clear_and_check(0);
    repeat (7) clear_and_check(1);

    // Level steps up to the cap
    for (int target = 10; target <= 160; target += 10) begin
      tries = 0;
      while (int'(total_lines) < target && tries < STEP_LIMIT) begin
        clear_and_check(3);
        tries++;
      end
      if (int'(total_lines) < target) begin
        timeouts++;
        $display("Timeout: total_lines never reached %0d", target);
      end
    end

    random_burst(200);

    start_game();
    check_tracker();
    check_score(score, to_bcd(0));
    clear_and_check(2);

    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/tetris_scoring_top.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_scoring_top
  import tetris_score_pkg::*;
#(
  parameter int SCORE_DIGITS = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          new_game,
  input  logic                          clear_valid,
  input  lines_t                        clear_lines,
  output bcd_digit_t [SCORE_DIGITS-1:0] score,
  output total_lines_t                  total_lines,
  output level_t                        level,
  output gravity_t                      gravity_frames
);

  // Points stage to accumulator
  logic                          points_valid;
  bcd_digit_t [POINT_DIGITS-1:0] points_bcd;

  clear_event_if ev_if ();

  line_clear_tracker u_tracker (
    .clk            (clk),
    .rst            (rst),
    .new_game       (new_game),
    .clear_valid    (clear_valid),
    .clear_lines    (clear_lines),
    .ev             (ev_if.source),
    .total_lines    (total_lines),
    .level          (level),
    .gravity_frames (gravity_frames)
  );

  clear_points_calc u_points (
    .clk          (clk),
    .rst          (rst),
    .new_game     (new_game),
    .ev           (ev_if.sink),
    .points_valid (points_valid),
    .points_bcd   (points_bcd)
  );

  bcd_score_accum #(
    .SCORE_DIGITS (SCORE_DIGITS)
  ) u_accum (
    .clk          (clk),
    .rst          (rst),
    .new_game     (new_game),
    .points_valid (points_valid),
    .points_bcd   (points_bcd),
    .score        (score)
  );

endmodule

`default_nettype wire

// File: src/bcd_score_accum.sv
`timescale 1ns/10ps
`default_nettype none

module bcd_score_accum
  import tetris_score_pkg::*;
#(
  parameter int SCORE_DIGITS = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          new_game,
  input  logic                          points_valid,
  input  bcd_digit_t [POINT_DIGITS-1:0] points_bcd,
  output bcd_digit_t [SCORE_DIGITS-1:0] score
);

  bcd_digit_t [SCORE_DIGITS-1:0] addend;
  bcd_digit_t [SCORE_DIGITS-1:0] score_next;
  logic [4:0]                    digit_sum;
  logic                          carry;

  // ==============================
  // Decimal add, low digit first
  // ==============================
  always_comb begin
    addend = '0;
    for (int i = 0; i < POINT_DIGITS && i < SCORE_DIGITS; i++) begin
      addend[i] = points_bcd[i];
    end
    carry = 1'b0;
    for (int i = 0; i < SCORE_DIGITS; i++) begin
      digit_sum = 5'(score[i]) + 5'(addend[i]) + 5'(carry);
      if (digit_sum >= 5'd10) begin
        score_next[i] = 4'(digit_sum - 5'd10);
        carry         = 1'b1;
      end else begin
        score_next[i] = digit_sum[3:0];
        carry         = 1'b0;
      end
    end
    // carry out of the top digit is dropped, so the score wraps
  end

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      score <= '0;
    end else if (points_valid) begin
      score <= score_next;
    end
  end

  // Each score digit stays decimal through every update
  for (genvar g = 0; g < SCORE_DIGITS; g++) begin : g_digit_chk
    assert property (@(posedge clk) disable iff (rst) score[g] < 4'd10);
  end

endmodule

`default_nettype wire

// File: src/clear_points_calc.sv
`timescale 1ns/10ps
`default_nettype none

module clear_points_calc
  import tetris_score_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          new_game,
  clear_event_if.sink                   ev,
  output logic                          points_valid,
  output bcd_digit_t [POINT_DIGITS-1:0] points_bcd
);

  logic                      s1_valid;
  points_t                   s1_points;
  points_t                   base;
  points_t                   bonus;
  points_t                   points_next;
  logic [4:0]                level_mult;
  streak_t                   bonus_steps;
  logic [4*POINT_DIGITS-1:0] bcd_work;

  // ==============================
  // Stage 1, binary points
  // ==============================
  always_comb begin
    if (ev.lines <= 3'd4) begin
      base = BASE_POINTS[ev.lines];
    end else begin
      base = '0;
    end
    level_mult = 5'(ev.level) + 5'd1;
    // Bonus stops growing after five clearing locks
    if (ev.streak > STREAK_BONUS_CAP) begin
      bonus_steps = streak_t'(STREAK_BONUS_CAP);
    end else begin
      bonus_steps = ev.streak;
    end
    if (ev.lines != 3'd0 && ev.streak != 4'd0) begin
      bonus = points_t'(bonus_steps) * points_t'(STREAK_BONUS_STEP);
    end else begin
      bonus = '0;
    end
    points_next = base * points_t'(level_mult) + bonus;
  end

  // ==============================
  // Stage 2, double dabble
  // ==============================
  always_comb begin
    bcd_work = '0;
    for (int b = $bits(points_t) - 1; b >= 0; b--) begin
      for (int d = 0; d < POINT_DIGITS; d++) begin
        if (bcd_work[4*d +: 4] >= 4'd5) begin
          bcd_work[4*d +: 4] = bcd_work[4*d +: 4] + 4'd3;
        end
      end
      bcd_work = {bcd_work[4*POINT_DIGITS-2:0], s1_points[b]};
    end
  end

  // Valid bits of both stages
  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      s1_valid     <= 1'b0;
      points_valid <= 1'b0;
    end else begin
      s1_valid     <= ev.valid;
      points_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ev.valid) begin
      s1_points <= points_next;
    end
    if (s1_valid) begin
      points_bcd <= bcd_work;
    end
  end

  // Decimal value of the BCD output
  function automatic int bcd_to_int(input bcd_digit_t [POINT_DIGITS-1:0] digits);
    int value;
    value = 0;
    for (int d = POINT_DIGITS - 1; d >= 0; d--) begin
      value = value * 10 + int'(digits[d]);
    end
    return value;
  endfunction

  // BCD result carries the stage 1 value one cycle later
  assert property (@(posedge clk) disable iff (rst)
    (s1_valid && !new_game) |=>
      points_valid && bcd_to_int(points_bcd) == int'($past(s1_points)));

endmodule

`default_nettype wire

// File: src/line_clear_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module line_clear_tracker
  import tetris_score_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          new_game,
  input  logic          clear_valid,
  input  lines_t        clear_lines,
  clear_event_if.source ev,
  output total_lines_t  total_lines,
  output level_t        level,
  output gravity_t      gravity_frames
);

  // Gravity frames per level
  localparam gravity_t GRAVITY_TABLE [MAX_LEVEL+1] = '{
    6'd40, 6'd37, 6'd34, 6'd30, 6'd26, 6'd21, 6'd15, 6'd12,
    6'd8,  6'd6,  6'd5,  6'd5,  6'd5,  6'd4,  6'd3,  6'd2
  };

  logic [8:0]   lines_sum;
  total_lines_t total_next;
  logic [7:0]   level_raw;
  level_t       level_next;
  streak_t      streak;
  streak_t      streak_next;

  // ==============================
  // Next totals
  // ==============================
  always_comb begin
    lines_sum  = {1'b0, total_lines} + 9'(clear_lines);
    // Saturate at 255
    total_next = lines_sum[8] ? 8'hFF : lines_sum[7:0];
    level_raw  = total_next / total_lines_t'(LINES_PER_LEVEL);
    level_next = (level_raw > MAX_LEVEL) ? level_t'(MAX_LEVEL) : level_raw[3:0];
    if (clear_lines != 3'd0) begin
      streak_next = (streak == streak_t'(STREAK_MAX)) ? streak : streak + 4'd1;
    end else begin
      streak_next = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      total_lines    <= '0;
      level          <= '0;
      gravity_frames <= GRAVITY_TABLE[0];
      streak         <= '0;
      ev.valid       <= 1'b0;
    end else begin
      ev.valid <= clear_valid;
      if (clear_valid) begin
        total_lines    <= total_next;
        level          <= level_next;
        gravity_frames <= GRAVITY_TABLE[level_next];
        streak         <= streak_next;
      end
    end
  end

  // Event fields carry the state before the update
  always_ff @(posedge clk) begin
    if (clear_valid) begin
      ev.lines  <= clear_lines;
      ev.level  <= level;
      ev.streak <= streak;
    end
  end

  // A lock never removes more than four rows
  assert property (@(posedge clk) disable iff (rst) clear_valid |-> clear_lines <= 3'd4);

endmodule

`default_nettype wire

// File: src/clear_event_if.sv
`timescale 1ns/10ps
`default_nettype none

// One accepted clear event, tracker to points calculation
interface clear_event_if
  import tetris_score_pkg::*;
();

  logic    valid;
  lines_t  lines;
  // Level and streak as they were before this event
  level_t  level;
  streak_t streak;

  modport source (
    output valid, lines, level, streak
  );

  modport sink (
    input valid, lines, level, streak
  );

endinterface

`default_nettype wire

// File: src/tetris_score_pkg.sv
`default_nettype none

package tetris_score_pkg;

  // ==============================
  // Widths with a meaning
  // ==============================

  // Rows removed by one lock
  typedef logic [2:0]  lines_t;
  typedef logic [7:0]  total_lines_t;
  typedef logic [3:0]  level_t;
  // Clearing locks before the current one
  typedef logic [3:0]  streak_t;
  // Frames per gravity step
  typedef logic [5:0]  gravity_t;
  // Largest event is 1200 x 16 + 500 = 19700
  typedef logic [15:0] points_t;
  typedef logic [3:0]  bcd_digit_t;

  // ==============================
  // Game constants
  // ==============================

  localparam int MAX_LEVEL       = 15;
  localparam int STREAK_MAX      = 15;
  localparam int POINT_DIGITS    = 5;
  localparam int LINES_PER_LEVEL = 10;

  // Classic base table, indexed by rows removed
  localparam points_t BASE_POINTS [5] = '{
    16'd0,
    16'd40,
    16'd100,
    16'd300,
    16'd1200
  };

  // Streak bonus per step and the step cap
  localparam int STREAK_BONUS_STEP = 100;
  localparam int STREAK_BONUS_CAP  = 5;

endpackage

`default_nettype wire
